//--- rtl/axi4l_params.svh
`ifndef AXI4L_PARAMS_SVH
`define AXI4L_PARAMS_SVH

// bus widths
`define AXI4L_ADDR_WID 32
`define AXI4L_DATA_WID 32

// register file size, word registers from offset 0
`define AXI4L_NUM_REGS 8

`endif

//--- rtl/reg_slice_pkg.sv
package reg_slice_pkg;

    typedef enum logic [1:0] {
        SLICE_BYPASS = 2'd0,  // wires only
        SLICE_LIGHT  = 2'd1,  // one entry, half rate
        SLICE_FULL   = 2'd2   // skid buffer, full rate
    } reg_slice_cfg_t;

    // peripheral reset lags by the channel latency
    function automatic int reset_pipe_stages(input reg_slice_cfg_t cfg);
        case (cfg)
            SLICE_BYPASS : return 0;
            default      : return 1;
        endcase
    endfunction

endpackage : reg_slice_pkg

//--- rtl/axi4l_pkg.sv
`include "axi4l_params.svh"

package axi4l_pkg;

    // only the two codes this subsystem produces
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        DECERR = 2'b11
    } axi4l_resp_t;

    // write address channel
    typedef struct packed {
        logic [`AXI4L_ADDR_WID-1:0] addr;
        logic [2:0]                 prot;
    } axi4l_aw_t;

    // write data channel
    typedef struct packed {
        logic [`AXI4L_DATA_WID-1:0]   data;
        logic [`AXI4L_DATA_WID/8-1:0] strb;  // one bit per byte lane
    } axi4l_w_t;

    // write response channel
    typedef struct packed {
        axi4l_resp_t resp;
    } axi4l_b_t;

    // read address channel, same fields as aw
    typedef struct packed {
        logic [`AXI4L_ADDR_WID-1:0] addr;
        logic [2:0]                 prot;
    } axi4l_ar_t;

    // read data channel
    typedef struct packed {
        logic [`AXI4L_DATA_WID-1:0] data;
        axi4l_resp_t                resp;
    } axi4l_r_t;

endpackage : axi4l_pkg

//--- rtl/util_pipe.sv
`timescale 1ns/10ps

module util_pipe #(
    parameter type DATA_T      = logic,
    parameter int  PIPE_STAGES = 1
) (
    input  logic  aclk,
    input  DATA_T data_in,
    output DATA_T data_out
);

    if (PIPE_STAGES == 0) begin : g_wire
        assign data_out = data_in;
    end else begin : g_regs
        DATA_T stage_q [PIPE_STAGES];

        always_ff @(posedge aclk) begin
            stage_q[0] <= data_in;
            for (int i = 1; i < PIPE_STAGES; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end

        assign data_out = stage_q[PIPE_STAGES-1];  // oldest stage
    end

endmodule : util_pipe

//--- rtl/axi_channel_slice.sv
`timescale 1ns/10ps

module axi_channel_slice #(
    parameter type                           PAYLOAD_T = logic,
    parameter reg_slice_pkg::reg_slice_cfg_t CFG       = reg_slice_pkg::SLICE_FULL
) (
    input  logic     aclk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  PAYLOAD_T in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output PAYLOAD_T out_data
);
    import reg_slice_pkg::*;

    if (CFG == SLICE_FULL) begin : g_full
        logic     main_valid_q;
        logic     skid_valid_q;
        PAYLOAD_T main_data_q;
        PAYLOAD_T skid_data_q;
        logic     in_fire;
        logic     main_free;

        assign in_ready  = !skid_valid_q;  // straight from a flop
        assign in_fire   = in_valid && !skid_valid_q;
        assign main_free = !main_valid_q || out_ready;

        always_ff @(posedge aclk) begin
            if (rst) begin
                main_valid_q <= 1'b0;
                skid_valid_q <= 1'b0;
            end else if (main_free) begin
                main_valid_q <= skid_valid_q || in_fire;
                skid_valid_q <= 1'b0;
            end else if (in_fire) begin
                skid_valid_q <= 1'b1;  // main stalled, park the beat
            end
        end

        always_ff @(posedge aclk) begin
            if (main_free) begin
                main_data_q <= skid_valid_q ? skid_data_q : in_data;
            end else if (in_fire) begin
                skid_data_q <= in_data;
            end
        end

        assign out_valid = main_valid_q;
        assign out_data  = main_data_q;
    end else if (CFG == SLICE_LIGHT) begin : g_light
        logic     hold_valid_q;
        PAYLOAD_T hold_data_q;

        // must drain before it refills
        assign in_ready = !hold_valid_q;

        always_ff @(posedge aclk) begin
            if (rst) begin
                hold_valid_q <= 1'b0;
            end else if (!hold_valid_q) begin
                hold_valid_q <= in_valid;
            end else if (out_ready) begin
                hold_valid_q <= 1'b0;
            end
        end

        always_ff @(posedge aclk) begin
            if (!hold_valid_q) begin
                hold_data_q <= in_data;
            end
        end

        assign out_valid = hold_valid_q;
        assign out_data  = hold_data_q;
    end else begin : g_bypass
        assign in_ready  = out_ready;
        assign out_valid = in_valid;
        assign out_data  = in_data;
    end

endmodule : axi_channel_slice

//--- rtl/axi4l_reg_slice.sv
`timescale 1ns/10ps

module axi4l_reg_slice #(
    parameter reg_slice_pkg::reg_slice_cfg_t CFG = reg_slice_pkg::SLICE_FULL
) (
    input  logic                 aclk,
    input  logic                 rst,
    // controller side
    input  logic                 s_aw_valid,
    output logic                 s_aw_ready,
    input  axi4l_pkg::axi4l_aw_t s_aw,
    input  logic                 s_w_valid,
    output logic                 s_w_ready,
    input  axi4l_pkg::axi4l_w_t  s_w,
    output logic                 s_b_valid,
    input  logic                 s_b_ready,
    output axi4l_pkg::axi4l_b_t  s_b,
    input  logic                 s_ar_valid,
    output logic                 s_ar_ready,
    input  axi4l_pkg::axi4l_ar_t s_ar,
    output logic                 s_r_valid,
    input  logic                 s_r_ready,
    output axi4l_pkg::axi4l_r_t  s_r,
    // peripheral side
    output logic                 m_aw_valid,
    input  logic                 m_aw_ready,
    output axi4l_pkg::axi4l_aw_t m_aw,
    output logic                 m_w_valid,
    input  logic                 m_w_ready,
    output axi4l_pkg::axi4l_w_t  m_w,
    input  logic                 m_b_valid,
    output logic                 m_b_ready,
    input  axi4l_pkg::axi4l_b_t  m_b,
    output logic                 m_ar_valid,
    input  logic                 m_ar_ready,
    output axi4l_pkg::axi4l_ar_t m_ar,
    input  logic                 m_r_valid,
    output logic                 m_r_ready,
    input  axi4l_pkg::axi4l_r_t  m_r,
    output logic                 periph_rst
);
    import axi4l_pkg::*;
    import reg_slice_pkg::*;

    axi_channel_slice #(.PAYLOAD_T(axi4l_aw_t), .CFG(CFG)) u_aw_slice (
        .aclk, .rst,
        .in_valid  (s_aw_valid), .in_ready (s_aw_ready), .in_data  (s_aw),
        .out_valid (m_aw_valid), .out_ready(m_aw_ready), .out_data (m_aw)
    );

    axi_channel_slice #(.PAYLOAD_T(axi4l_w_t), .CFG(CFG)) u_w_slice (
        .aclk, .rst,
        .in_valid  (s_w_valid), .in_ready (s_w_ready), .in_data  (s_w),
        .out_valid (m_w_valid), .out_ready(m_w_ready), .out_data (m_w)
    );

    // responses run peripheral to controller
    axi_channel_slice #(.PAYLOAD_T(axi4l_b_t), .CFG(CFG)) u_b_slice (
        .aclk, .rst,
        .in_valid  (m_b_valid), .in_ready (m_b_ready), .in_data  (m_b),
        .out_valid (s_b_valid), .out_ready(s_b_ready), .out_data (s_b)
    );

    axi_channel_slice #(.PAYLOAD_T(axi4l_ar_t), .CFG(CFG)) u_ar_slice (
        .aclk, .rst,
        .in_valid  (s_ar_valid), .in_ready (s_ar_ready), .in_data  (s_ar),
        .out_valid (m_ar_valid), .out_ready(m_ar_ready), .out_data (m_ar)
    );

    axi_channel_slice #(.PAYLOAD_T(axi4l_r_t), .CFG(CFG)) u_r_slice (
        .aclk, .rst,
        .in_valid  (m_r_valid), .in_ready (m_r_ready), .in_data  (m_r),
        .out_valid (s_r_valid), .out_ready(s_r_ready), .out_data (s_r)
    );

    // peripheral leaves reset in step with the channel latency
    util_pipe #(
        .DATA_T      (logic),
        .PIPE_STAGES (reset_pipe_stages(CFG))
    ) u_rst_pipe (
        .aclk,
        .data_in  (rst),
        .data_out (periph_rst)
    );

endmodule : axi4l_reg_slice

//--- rtl/axi4l_reg_file.sv
`timescale 1ns/10ps
`include "axi4l_params.svh"

module axi4l_reg_file (
    input  logic                 aclk,
    input  logic                 rst,
    input  logic                 aw_valid,
    output logic                 aw_ready,
    input  axi4l_pkg::axi4l_aw_t aw,
    input  logic                 w_valid,
    output logic                 w_ready,
    input  axi4l_pkg::axi4l_w_t  w,
    output logic                 b_valid,
    input  logic                 b_ready,
    output axi4l_pkg::axi4l_b_t  b,
    input  logic                 ar_valid,
    output logic                 ar_ready,
    input  axi4l_pkg::axi4l_ar_t ar,
    output logic                 r_valid,
    input  logic                 r_ready,
    output axi4l_pkg::axi4l_r_t  r
);
    import axi4l_pkg::*;

    localparam int ADDR_WID = `AXI4L_ADDR_WID;
    localparam int DATA_WID = `AXI4L_DATA_WID;
    localparam int NUM_REGS = `AXI4L_NUM_REGS;
    localparam int IDX_WID  = $clog2(NUM_REGS);
    localparam logic [ADDR_WID-1:0] REG_SPAN = ADDR_WID'(NUM_REGS * 4);

    logic [DATA_WID-1:0] regs_q [NUM_REGS];
    logic                aw_held_q;
    logic                w_held_q;
    logic [ADDR_WID-1:0] aw_addr_q;
    axi4l_w_t            w_q;
    logic                b_valid_q;
    logic                r_valid_q;
    axi4l_b_t            b_q;
    axi4l_r_t            r_q;
    logic                aw_fire;
    logic                w_fire;
    logic                ar_fire;
    logic                wr_go;
    logic [ADDR_WID-1:0] wr_addr;
    axi4l_w_t            wr_data;
    logic                wr_hit;
    logic                rd_hit;
    logic [IDX_WID-1:0]  wr_idx;
    logic [IDX_WID-1:0]  rd_idx;

    // no new request of a kind while its response waits
    assign aw_ready = !aw_held_q && !b_valid_q;
    assign w_ready  = !w_held_q && !b_valid_q;
    assign ar_ready = !r_valid_q;

    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;
    assign ar_fire = ar_valid && ar_ready;

    // write once both halves are in hand
    assign wr_go   = (aw_fire || aw_held_q) && (w_fire || w_held_q);
    assign wr_addr = aw_held_q ? aw_addr_q : aw.addr;
    assign wr_data = w_held_q ? w_q : w;
    assign wr_hit  = wr_addr < REG_SPAN;
    assign wr_idx  = wr_addr[IDX_WID+1:2];  // byte offset ignored
    assign rd_hit  = ar.addr < REG_SPAN;
    assign rd_idx  = ar.addr[IDX_WID+1:2];

    always_ff @(posedge aclk) begin
        if (rst) begin
            aw_held_q <= 1'b0;
            w_held_q  <= 1'b0;
            b_valid_q <= 1'b0;
            r_valid_q <= 1'b0;
        end else begin
            aw_held_q <= wr_go ? 1'b0 : (aw_held_q || aw_fire);
            w_held_q  <= wr_go ? 1'b0 : (w_held_q || w_fire);
            if (wr_go) begin
                b_valid_q <= 1'b1;
            end else if (b_ready) begin
                b_valid_q <= 1'b0;
            end
            if (ar_fire) begin
                r_valid_q <= 1'b1;
            end else if (r_ready) begin
                r_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (aw_fire) aw_addr_q <= aw.addr;
        if (w_fire) w_q <= w;
        if (wr_go) b_q.resp <= wr_hit ? OKAY : DECERR;
        if (ar_fire) begin
            r_q.data <= rd_hit ? regs_q[rd_idx] : '0;
            r_q.resp <= rd_hit ? OKAY : DECERR;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_go && wr_hit) begin
            for (int j = 0; j < DATA_WID / 8; j++) begin
                if (wr_data.strb[j]) regs_q[wr_idx][8*j +: 8] <= wr_data.data[8*j +: 8];
            end
        end
    end

    assign b_valid = b_valid_q;
    assign b       = b_q;
    assign r_valid = r_valid_q;
    assign r       = r_q;

endmodule : axi4l_reg_file

//--- rtl/axi4l_slice_top.sv
`timescale 1ns/10ps

module axi4l_slice_top #(
    parameter reg_slice_pkg::reg_slice_cfg_t SLICE_CFG = reg_slice_pkg::SLICE_FULL
) (
    input  logic                 aclk,
    input  logic                 rst,
    input  logic                 s_aw_valid,
    output logic                 s_aw_ready,
    input  axi4l_pkg::axi4l_aw_t s_aw,
    input  logic                 s_w_valid,
    output logic                 s_w_ready,
    input  axi4l_pkg::axi4l_w_t  s_w,
    output logic                 s_b_valid,
    input  logic                 s_b_ready,
    output axi4l_pkg::axi4l_b_t  s_b,
    input  logic                 s_ar_valid,
    output logic                 s_ar_ready,
    input  axi4l_pkg::axi4l_ar_t s_ar,
    output logic                 s_r_valid,
    input  logic                 s_r_ready,
    output axi4l_pkg::axi4l_r_t  s_r
);
    import axi4l_pkg::*;

    // slice to register file
    logic      aw_valid, aw_ready;
    axi4l_aw_t aw;
    logic      w_valid, w_ready;
    axi4l_w_t  w;
    logic      b_valid, b_ready;
    axi4l_b_t  b;
    logic      ar_valid, ar_ready;
    axi4l_ar_t ar;
    logic      r_valid, r_ready;
    axi4l_r_t  r;
    logic      periph_rst;

    axi4l_reg_slice #(.CFG(SLICE_CFG)) u_slice (
        .aclk, .rst,
        .s_aw_valid, .s_aw_ready, .s_aw,
        .s_w_valid, .s_w_ready, .s_w,
        .s_b_valid, .s_b_ready, .s_b,
        .s_ar_valid, .s_ar_ready, .s_ar,
        .s_r_valid, .s_r_ready, .s_r,
        .m_aw_valid (aw_valid), .m_aw_ready (aw_ready), .m_aw (aw),
        .m_w_valid  (w_valid),  .m_w_ready  (w_ready),  .m_w  (w),
        .m_b_valid  (b_valid),  .m_b_ready  (b_ready),  .m_b  (b),
        .m_ar_valid (ar_valid), .m_ar_ready (ar_ready), .m_ar (ar),
        .m_r_valid  (r_valid),  .m_r_ready  (r_ready),  .m_r  (r),
        .periph_rst
    );

    axi4l_reg_file u_regs (
        .aclk,
        .rst (periph_rst),  // delayed copy from the slice
        .aw_valid, .aw_ready, .aw,
        .w_valid, .w_ready, .w,
        .b_valid, .b_ready, .b,
        .ar_valid, .ar_ready, .ar,
        .r_valid, .r_ready, .r
    );

endmodule : axi4l_slice_top

//--- tests/axi4l_slice_tasks.svh
// expected response and read data from the register map rules
function automatic axi4l_resp_t predict_resp(input logic [ADDR_WID-1:0] addr);
    return (addr < REG_SPAN) ? OKAY : DECERR;
endfunction

function automatic logic [DATA_WID-1:0] predict_data(input logic [ADDR_WID-1:0] addr);
    return (addr < REG_SPAN) ? model[addr[IDX_WID+1:2]] : '0;
endfunction

task automatic apply_to_model(
    input logic [ADDR_WID-1:0] addr,
    input logic [DATA_WID-1:0] data,
    input logic [STRB_WID-1:0] strb
);
    if (addr < REG_SPAN) begin  // out of range writes are dropped
        for (int j = 0; j < STRB_WID; j++) begin
            if (strb[j]) begin
                model[addr[IDX_WID+1:2]][8*j +: 8] = data[8*j +: 8];
            end
        end
    end
endtask

// order 0 offers aw and w together, 1 aw first, 2 w first
task automatic write_txn(
    input  logic [ADDR_WID-1:0] addr,
    input  logic [DATA_WID-1:0] data,
    input  logic [STRB_WID-1:0] strb,
    input  int                  order,
    output axi4l_resp_t         resp
);
    logic     aw_done;
    logic     w_done;
    logic     b_done;
    logic     b_stalled;
    axi4l_b_t b_seen;
    int       cycles;
    aw_done   = 1'b0;
    w_done    = 1'b0;
    b_done    = 1'b0;
    b_stalled = 1'b0;
    b_seen    = '0;
    cycles    = 0;
    resp      = OKAY;
    while (!b_done && cycles < TXN_CYCLES) begin
        @(negedge aclk);
        s_aw.addr  = addr;
        s_aw.prot  = 3'b000;
        s_w.data   = data;
        s_w.strb   = strb;
        s_aw_valid = !aw_done && (order != 2 || w_done);
        s_w_valid  = !w_done && (order != 1 || aw_done);
        s_b_ready  = stall_en ? lfsr_bit() : 1'b1;
        #1;  // ready paths settled, rising edge still ahead
        if (b_stalled && (!s_b_valid || s_b !== b_seen)) begin
            report_fault("write response dropped or changed while bready was low");
        end
        aw_done   = aw_done || (s_aw_valid && s_aw_ready);
        w_done    = w_done || (s_w_valid && s_w_ready);
        b_done    = s_b_valid && s_b_ready;
        b_stalled = s_b_valid && !s_b_ready;
        b_seen    = s_b;
        if (b_done) begin
            resp = s_b.resp;
        end
        cycles++;
    end
    if (!b_done) begin
        report_fault($sformatf("no write response for address %h", addr));
    end
    @(negedge aclk);
    s_aw_valid = 1'b0;
    s_w_valid  = 1'b0;
    s_b_ready  = 1'b0;
    #1;
    if (b_done && s_b_valid) begin
        report_fault("second write response after a single write");
    end
endtask

task automatic read_txn(
    input  logic [ADDR_WID-1:0] addr,
    output logic [DATA_WID-1:0] data,
    output axi4l_resp_t         resp
);
    logic     ar_done;
    logic     r_done;
    logic     r_stalled;
    axi4l_r_t r_seen;
    int       cycles;
    ar_done   = 1'b0;
    r_done    = 1'b0;
    r_stalled = 1'b0;
    r_seen    = '0;
    cycles    = 0;
    data      = '0;
    resp      = OKAY;
    while (!r_done && cycles < TXN_CYCLES) begin
        @(negedge aclk);
        s_ar.addr  = addr;
        s_ar.prot  = 3'b000;
        s_ar_valid = !ar_done;
        s_r_ready  = stall_en ? lfsr_bit() : 1'b1;
        #1;
        if (r_stalled && (!s_r_valid || s_r !== r_seen)) begin
            report_fault("read data dropped or changed while rready was low");
        end
        ar_done   = ar_done || (s_ar_valid && s_ar_ready);
        r_done    = s_r_valid && s_r_ready;
        r_stalled = s_r_valid && !s_r_ready;
        r_seen    = s_r;
        if (r_done) begin
            data = s_r.data;
            resp = s_r.resp;
        end
        cycles++;
    end
    if (!r_done) begin
        report_fault($sformatf("no read data for address %h", addr));
    end
    @(negedge aclk);
    s_ar_valid = 1'b0;
    s_r_ready  = 1'b0;
    #1;
    if (r_done && s_r_valid) begin
        report_fault("second read data beat after a single read");
    end
endtask

task automatic verify_write(
    input logic [ADDR_WID-1:0] addr,
    input logic [DATA_WID-1:0] data,
    input logic [STRB_WID-1:0] strb,
    input int                  order
);
    axi4l_resp_t resp;
    write_txn(addr, data, strb, order, resp);
    apply_to_model(addr, data, strb);
    check_resp(predict_resp(addr), resp);
endtask

task automatic verify_read(input logic [ADDR_WID-1:0] addr);
    logic [DATA_WID-1:0] data;
    axi4l_resp_t         resp;
    read_txn(addr, data, resp);
    check_data(predict_data(addr), data);
    check_resp(predict_resp(addr), resp);
endtask

task automatic read_sweep();
    for (int i = 0; i < NUM_REGS; i++) begin
        verify_read(ADDR_WID'(i * 4));
    end
endtask

task automatic reset_state();
    cur_test = "reset_state";
    repeat (4) begin
        @(negedge aclk);
        #1;
        if (s_b_valid || s_r_valid) begin
            report_fault("bvalid or rvalid high after reset");
        end
    end
    read_sweep();
    finish_test();
endtask

task automatic full_strobe_rw();
    cur_test = "full_strobe_rw";
    for (int i = 0; i < NUM_REGS; i++) begin
        verify_write(ADDR_WID'(i * 4), lfsr_bits(DATA_WID), '1, 0);
        verify_read(ADDR_WID'(i * 4));
    end
    finish_test();
endtask

task automatic partial_strobe();
    cur_test = "partial_strobe";
    // low address bits set too, the decoder ignores them
    for (int i = 0; i < NUM_REGS; i++) begin
        verify_write(ADDR_WID'(i * 4 + i % 4), lfsr_bits(DATA_WID), STRB_WID'(i + 5), 0);
    end
    read_sweep();
    finish_test();
endtask

task automatic decode_error();
    logic [ADDR_WID-1:0] addr;
    cur_test = "decode_error";
    for (int i = 0; i < 4; i++) begin
        addr = (i == 3) ? '1 : REG_SPAN << i;
        verify_write(addr, lfsr_bits(DATA_WID), '1, i % 3);
        verify_read(addr);
    end
    read_sweep();  // no register may have moved
    finish_test();
endtask

task automatic stalled_responses();
    logic [ADDR_WID-1:0] addr;
    cur_test = "stalled_responses";
    stall_en = 1'b1;
    for (int i = 0; i < 16; i++) begin
        addr = ADDR_WID'(lfsr_bits(IDX_WID)) << 2;
        verify_write(addr, lfsr_bits(DATA_WID), '1, 0);
        verify_read(addr);
    end
    stall_en = 1'b0;
    finish_test();
endtask

task automatic mixed_order_writes();
    cur_test = "mixed_order_writes";
    for (int i = 0; i < 16; i++) begin
        verify_write(ADDR_WID'((i % NUM_REGS) * 4), lfsr_bits(DATA_WID),
                     STRB_WID'(lfsr_bits(STRB_WID)), i % 3);
    end
    read_sweep();
    finish_test();
endtask

//--- tests/axi4l_slice_tb.sv
`timescale 1ns/10ps
`include "axi4l_params.svh"

module axi4l_slice_tb #(
    parameter int SLICE_CFG = 2  // 0 bypass, 1 light, 2 full
);
    import axi4l_pkg::*;
    import reg_slice_pkg::*;

    localparam int ADDR_WID     = `AXI4L_ADDR_WID;
    localparam int DATA_WID     = `AXI4L_DATA_WID;
    localparam int STRB_WID     = DATA_WID / 8;
    localparam int NUM_REGS     = `AXI4L_NUM_REGS;
    localparam int IDX_WID      = $clog2(NUM_REGS);
    localparam int RESET_CYCLES = 8;
    localparam int TXN_CYCLES   = 40;   // handshake limit per transaction
    localparam int TXN_TOTAL    = 112;  // transactions over all six tests
    localparam int MARGIN       = 2;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + TXN_TOTAL * TXN_CYCLES) * 10 * MARGIN;
    localparam logic [ADDR_WID-1:0] REG_SPAN = ADDR_WID'(NUM_REGS * 4);

    logic      aclk;
    logic      rst;
    logic      s_aw_valid;
    logic      s_aw_ready;
    axi4l_aw_t s_aw;
    logic      s_w_valid;
    logic      s_w_ready;
    axi4l_w_t  s_w;
    logic      s_b_valid;
    logic      s_b_ready;
    axi4l_b_t  s_b;
    logic      s_ar_valid;
    logic      s_ar_ready;
    axi4l_ar_t s_ar;
    logic      s_r_valid;
    logic      s_r_ready;
    axi4l_r_t  s_r;

    logic [DATA_WID-1:0] model [NUM_REGS];  // predicted register contents
    logic [15:0]         lfsr_q;
    logic                stall_en;          // random bready and rready
    string               cur_test;
    int                  err_cnt;
    int                  test_errs;
    int                  check_cnt;
    int                  test_cnt;

    axi4l_slice_top #(
        .SLICE_CFG (reg_slice_cfg_t'(SLICE_CFG))
    ) u_dut (
        .aclk, .rst,
        .s_aw_valid, .s_aw_ready, .s_aw,
        .s_w_valid, .s_w_ready, .s_w,
        .s_b_valid, .s_b_ready, .s_b,
        .s_ar_valid, .s_ar_ready, .s_ar,
        .s_r_valid, .s_r_ready, .s_r
    );

    initial aclk = 1'b0;
    always #5 aclk = ~aclk;

    // galois form, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic out_bit;
        out_bit = lfsr_q[0];
        lfsr_q  = lfsr_q >> 1;
        if (out_bit) begin
            lfsr_q = lfsr_q ^ 16'hB400;
        end
        return out_bit;
    endfunction

    function automatic logic [DATA_WID-1:0] lfsr_bits(input int nbits);
        logic [DATA_WID-1:0] val;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            val = {val[DATA_WID-2:0], lfsr_bit()};
        end
        return val;
    endfunction

    task automatic report_fault(input string msg);
        $display("%s: %s", cur_test, msg);
        err_cnt++;
        test_errs++;
    endtask

    task automatic check_resp(input axi4l_resp_t exp, input axi4l_resp_t act);
        check_cnt++;
        if (act !== exp) begin
            $display("Error %s: expected resp %b, actual resp %b", cur_test, exp, act);
            err_cnt++;
            test_errs++;
        end
    endtask

    task automatic check_data(input logic [DATA_WID-1:0] exp, input logic [DATA_WID-1:0] act);
        check_cnt++;
        if (act !== exp) begin
            $display("Error %s: expected data %h, actual data %h", cur_test, exp, act);
            err_cnt++;
            test_errs++;
        end
    endtask

    task automatic finish_test();
        $display("test %s finished with %0d errors", cur_test, test_errs);
        test_cnt++;
        test_errs = 0;
    endtask

    `include "axi4l_slice_tasks.svh"

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        lfsr_q     = 16'd45211;
        stall_en   = 1'b0;
        err_cnt    = 0;
        test_errs  = 0;
        check_cnt  = 0;
        test_cnt   = 0;
        rst        = 1'b1;
        s_aw_valid = 1'b0;
        s_aw       = '0;
        s_w_valid  = 1'b0;
        s_w        = '0;
        s_b_ready  = 1'b0;
        s_ar_valid = 1'b0;
        s_ar       = '0;
        s_r_ready  = 1'b0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model[i] = '0;
        end
        repeat (RESET_CYCLES) @(negedge aclk);
        rst = 1'b0;

        reset_state();
        full_strobe_rw();
        partial_strobe();
        decode_error();
        stalled_responses();
        mixed_order_writes();

        $display("summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : axi4l_slice_tb

//--- axi4l_slice_top.f
+incdir+rtl
+incdir+tests
rtl/reg_slice_pkg.sv
rtl/axi4l_pkg.sv
rtl/util_pipe.sv
rtl/axi_channel_slice.sv
rtl/axi4l_reg_slice.sv
rtl/axi4l_reg_file.sv
rtl/axi4l_slice_top.sv
tests/axi4l_slice_tb.sv

//--- Makefile
# Verilator build and run for the AXI4-Lite register slice testbench
# SLICE_CFG selects the slice mode: 0 bypass, 1 light, 2 full

VERILATOR  ?= verilator
SLICE_CFG  ?= 2
FLIST      ?= axi4l_slice_top.f
TB_TOP     ?= axi4l_slice_tb
RTL_TOP    ?= axi4l_slice_top
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FLIST) \
		--top-module $(TB_TOP) -GSLICE_CFG=$(SLICE_CFG)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
